// File: src/hist_pkg.sv
// History subsystem types
`default_nettype none

package hist_pkg;

	localparam int unsigned NUM_REGS = 32;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// Decode announcement of a register write.
	typedef struct packed {
		logic     valid;
		word_t    pc;
		reg_idx_t dest;
	} dec_req_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		reg_idx_t dest;
		word_t    data;
		word_t    cause;     // Zero when the instruction completed cleanly.
		word_t    miss_addr;
	} wb_rpt_t;

	// One slot of the history queue.
	typedef struct packed {
		logic     finished;
		word_t    cause;
		word_t    miss_addr;
		word_t    pc;
		reg_idx_t dest;
		word_t    old_value; // Register value before this instruction.
	} hist_entry_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		word_t    value;
	} rec_wr_t;

	typedef struct packed {
		word_t mepc;
		word_t mcause;
		word_t mtval;
	} exc_info_t;

endpackage

`default_nettype wire

// File: src/reg_file.sv
// Architectural register file
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  wire                clk_i,
	input  wire                rst_i,
	input  wire hist_pkg::wb_rpt_t  wb_i,
	input  wire hist_pkg::rec_wr_t  rec_i,
	input  wire                recovering_i,
	input  wire hist_pkg::reg_idx_t old_addr_i,
	input  wire hist_pkg::reg_idx_t dbg_addr_i,
	output hist_pkg::word_t    old_value_o,
	output hist_pkg::word_t    dbg_data_o
);
	import hist_pkg::*;

	word_t regs_q [NUM_REGS];
	logic  rec_we;
	logic  wb_we;

	// Register 0 is never written.
	assign rec_we = rec_i.valid && (rec_i.dest != '0);
	assign wb_we  = wb_i.valid && !recovering_i && (wb_i.dest != '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (rec_we) begin
			regs_q[rec_i.dest] <= rec_i.value; // Replay has priority.
		end else if (wb_we) begin
			regs_q[wb_i.dest] <= wb_i.data;
		end
	end

	// Old value for the entry being enqueued.
	assign old_value_o = (old_addr_i == '0) ? '0 : regs_q[old_addr_i];

	assign dbg_data_o = (dbg_addr_i == '0) ? '0 : regs_q[dbg_addr_i];

endmodule

`default_nettype wire

// File: src/hist_queue.sv
// History queue and recovery sequencer
`timescale 1ns/1ns
`default_nettype none

module hist_queue #(
	parameter int unsigned HIST_DEPTH = 16
) (
	input  wire                    clk_i,
	input  wire                    rst_i,
	input  wire hist_pkg::dec_req_t dec_i,
	input  wire hist_pkg::word_t    old_value_i,
	input  wire hist_pkg::wb_rpt_t  wb_i,
	output hist_pkg::reg_idx_t     dec_dest_o,
	output logic                   stall_o,
	output logic                   recovering_o,
	output logic                   kill_o,
	output hist_pkg::word_t        kill_pc_o,
	output hist_pkg::rec_wr_t      rec_o,
	output logic                   exc_load_o,
	output hist_pkg::exc_info_t    exc_info_o
);
	import hist_pkg::*;

	localparam int unsigned PTR_W = $clog2(HIST_DEPTH);

	typedef enum logic [1:0] {
		ST_RUN,
		ST_KILL,
		ST_REPLAY
	} state_t;

	hist_entry_t      queue_q [HIST_DEPTH];
	logic [PTR_W-1:0] head_q;
	logic [PTR_W-1:0] tail_q;
	logic [PTR_W-1:0] rec_idx_q;
	logic [PTR_W:0]   count_q;
	state_t           state_q;

	logic             full;
	logic             enq;
	logic             head_done;
	logic             retire;
	logic             fault;
	logic             wb_hit;
	logic [PTR_W-1:0] wb_idx;
	word_t            old_value;

	assign full         = (count_q == (PTR_W + 1)'(HIST_DEPTH));
	assign recovering_o = (state_q != ST_RUN);
	assign stall_o      = full || recovering_o;
	assign enq          = dec_i.valid && !stall_o;
	assign dec_dest_o   = dec_i.dest;

	// Head entry has completed; it either retires or faults.
	assign head_done = (state_q == ST_RUN) && (count_q != '0) && queue_q[head_q].finished;
	assign retire    = head_done && (queue_q[head_q].cause == '0);
	assign fault     = head_done && (queue_q[head_q].cause != '0);

	// A writeback to the same register this cycle lands before the new entry.
	always_comb begin
		old_value = old_value_i;
		if (wb_i.valid && !recovering_o && (wb_i.dest == dec_i.dest) && (dec_i.dest != '0)) begin
			old_value = wb_i.data;
		end
	end

	// Find the outstanding unfinished entry with the writeback PC.
	always_comb begin
		logic [PTR_W-1:0] offset;
		wb_hit = 1'b0;
		wb_idx = '0;
		for (int i = 0; i < HIST_DEPTH; i++) begin
			offset = PTR_W'(i) - head_q; // Age relative to the head.
			if (!wb_hit && ({1'b0, offset} < count_q) && !queue_q[i].finished &&
			    (queue_q[i].pc == wb_i.pc)) begin
				wb_hit = 1'b1;
				wb_idx = PTR_W'(i);
			end
		end
		wb_hit = wb_hit && wb_i.valid && (state_q == ST_RUN);
	end

	always_ff @(posedge clk_i) begin
		if (enq) begin
			queue_q[tail_q] <= '{
				finished:  1'b0,
				cause:     '0,
				miss_addr: '0,
				pc:        dec_i.pc,
				dest:      dec_i.dest,
				old_value: old_value
			};
		end
		if (wb_hit) begin
			queue_q[wb_idx].finished  <= 1'b1;
			queue_q[wb_idx].cause     <= wb_i.cause;
			queue_q[wb_idx].miss_addr <= wb_i.miss_addr;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q   <= ST_RUN;
			head_q    <= '0;
			tail_q    <= '0;
			rec_idx_q <= '0;
			count_q   <= '0;
		end else begin
			case (state_q)
				ST_RUN: begin
					if (enq) begin
						tail_q <= tail_q + PTR_W'(1);
					end
					if (retire) begin
						head_q <= head_q + PTR_W'(1);
					end
					count_q <= count_q + (PTR_W + 1)'(enq) - (PTR_W + 1)'(retire);
					if (fault) begin
						state_q <= ST_KILL;
					end
				end
				ST_KILL: begin
					rec_idx_q <= tail_q - PTR_W'(1); // Start at the youngest.
					state_q   <= ST_REPLAY;
				end
				ST_REPLAY: begin
					if (rec_idx_q == head_q) begin
						tail_q  <= head_q; // Queue is now empty.
						count_q <= '0;
						state_q <= ST_RUN;
					end else begin
						rec_idx_q <= rec_idx_q - PTR_W'(1);
					end
				end
				default: state_q <= ST_RUN;
			endcase
		end
	end

	assign kill_o    = (state_q == ST_KILL);
	assign kill_pc_o = queue_q[head_q].pc;

	assign rec_o = '{
		valid: (state_q == ST_REPLAY),
		dest:  queue_q[rec_idx_q].dest,
		value: queue_q[rec_idx_q].old_value
	};

	// Last replay step restores the faulting entry itself.
	assign exc_load_o = (state_q == ST_REPLAY) && (rec_idx_q == head_q);

	assign exc_info_o = '{
		mepc:   queue_q[head_q].pc,
		mcause: queue_q[head_q].cause,
		mtval:  queue_q[head_q].miss_addr
	};

endmodule

`default_nettype wire

// File: src/exc_regs.sv
// Exception register block
`timescale 1ns/1ns
`default_nettype none

module exc_regs (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire                     load_i,
	input  wire hist_pkg::exc_info_t info_i,
	output logic                    exc_valid_o,
	output hist_pkg::exc_info_t     exc_o
);
	import hist_pkg::*;

	exc_info_t info_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			exc_valid_o <= 1'b0;
			info_q      <= '0;
		end else begin
			exc_valid_o <= load_i; // One cycle strobe per load.
			if (load_i) begin
				info_q <= info_i;
			end
		end
	end

	// Held until the next exception.
	assign exc_o = info_q;

endmodule

`default_nettype wire

// File: src/hist_top.sv
// Precise exception subsystem top
`timescale 1ns/1ns
`default_nettype none

module hist_top #(
	parameter int unsigned HIST_DEPTH = 16
) (
	input  wire                     clk_i,
	input  wire                     rst_i,
	input  wire hist_pkg::dec_req_t  dec_i,
	input  wire hist_pkg::wb_rpt_t   wb_i,
	input  wire hist_pkg::reg_idx_t  dbg_addr_i,
	output logic                    stall_o,
	output logic                    kill_o,
	output hist_pkg::word_t         kill_pc_o,
	output logic                    exc_valid_o,
	output hist_pkg::exc_info_t     exc_o,
	output hist_pkg::word_t         dbg_data_o
);
	import hist_pkg::*;

	reg_idx_t  dec_dest;
	word_t     old_value;
	rec_wr_t   rec;
	logic      recovering;
	logic      exc_load;
	exc_info_t exc_info;

	reg_file reg_file_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.wb_i         (wb_i),
		.rec_i        (rec),
		.recovering_i (recovering),
		.old_addr_i   (dec_dest),
		.dbg_addr_i   (dbg_addr_i),
		.old_value_o  (old_value),
		.dbg_data_o   (dbg_data_o)
	);

	hist_queue #(
		.HIST_DEPTH (HIST_DEPTH)
	) hist_queue_i (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.dec_i        (dec_i),
		.old_value_i  (old_value),
		.wb_i         (wb_i),
		.dec_dest_o   (dec_dest),
		.stall_o      (stall_o),
		.recovering_o (recovering),
		.kill_o       (kill_o),
		.kill_pc_o    (kill_pc_o),
		.rec_o        (rec),
		.exc_load_o   (exc_load),
		.exc_info_o   (exc_info)
	);

	exc_regs exc_regs_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.load_i      (exc_load),
		.info_i      (exc_info),
		.exc_valid_o (exc_valid_o),
		.exc_o       (exc_o)
	);

endmodule

`default_nettype wire

// File: test/hist_assertions.sv
// History queue assertions
`timescale 1ns/1ns
`default_nettype none

module hist_assertions (
	input wire                    clk_i,
	input wire                    rst_i,
	input wire                    stall_i,
	input wire                    kill_i,
	input wire hist_pkg::rec_wr_t rec_i,
	input wire                    exc_load_i
);
	int unsigned fail_count = 0; // Read by the testbench at the end.

	reset_idle: assert property (@(posedge clk_i)
		rst_i |=> !stall_i && !kill_i && !rec_i.valid && !exc_load_i)
		else begin
			fail_count++;
			$error("Control output active in the cycle after reset");
		end

	// Replay only runs while decode is held off.
	rec_stalls: assert property (@(posedge clk_i) disable iff (rst_i)
		rec_i.valid |-> stall_i)
		else begin
			fail_count++;
			$error("Recovery write while stall is low");
		end

	kill_alone: assert property (@(posedge clk_i) disable iff (rst_i)
		!(kill_i && rec_i.valid))
		else begin
			fail_count++;
			$error("Kill and recovery write in the same cycle");
		end

	// A one-entry replay loads directly after the kill.
	load_order: assert property (@(posedge clk_i) disable iff (rst_i)
		exc_load_i |-> $past(rec_i.valid || kill_i))
		else begin
			fail_count++;
			$error("Exception load without a preceding recovery step");
		end

endmodule

bind hist_queue hist_assertions hist_assertions_i (
	.clk_i      (clk_i),
	.rst_i      (rst_i),
	.stall_i    (stall_o),
	.kill_i     (kill_o),
	.rec_i      (rec_o),
	.exc_load_i (exc_load_o)
);

`default_nettype wire

// File: test/hist_top_tb.sv
// History subsystem testbench
`timescale 1ns/1ns
`default_nettype none

module hist_top_tb;
	import hist_pkg::*;

	localparam int unsigned HIST_DEPTH = 16;
	localparam int TIMEOUT = 200;
	localparam int W_KILL = 0;
	localparam int W_EXC = 1;
	localparam int W_FREE = 2;

	logic      clk_i;
	logic      rst_i;
	dec_req_t  dec;
	wb_rpt_t   wb;
	reg_idx_t  dbg_addr;
	logic      stall;
	logic      kill;
	word_t     kill_pc;
	logic      exc_valid;
	exc_info_t exc;
	word_t     dbg_data;

	int          errors;
	int          seed;
	logic        quiet; // Kill and exception strobe must stay low.
	word_t       next_pc;
	word_t       model_regs [32];
	hist_entry_t model_q [$]; // Outstanding entries, oldest first.
	word_t       fill_pcs [HIST_DEPTH];
	reg_idx_t    fill_dests [HIST_DEPTH];

	hist_top #(
		.HIST_DEPTH (HIST_DEPTH)
	) hist_top_i (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.dec_i       (dec),
		.wb_i        (wb),
		.dbg_addr_i  (dbg_addr),
		.stall_o     (stall),
		.kill_o      (kill),
		.kill_pc_o   (kill_pc),
		.exc_valid_o (exc_valid),
		.exc_o       (exc),
		.dbg_data_o  (dbg_data)
	);

	initial clk_i = 1'b0;
	always #50 clk_i = ~clk_i;

	task automatic step();
		@(posedge clk_i);
		#1;
		if (quiet) begin
			check("kill_o", 32'd0, word_t'(kill));
			check("exc_valid_o", 32'd0, word_t'(exc_valid));
		end
	endtask

	task automatic idle(input int n);
		repeat (n) step();
	endtask

	task automatic check(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic read_reg(input reg_idx_t idx);
		dbg_addr = idx;
		#1;
		if (dbg_data !== model_regs[idx]) begin
			errors++;
			$display("Mismatch at %0t: dbg_data_o for x%0d expected %h, got %h",
				$time, idx, model_regs[idx], dbg_data);
		end
	endtask

	task automatic check_reg(input reg_idx_t idx);
		read_reg(idx);
		step();
	endtask

	// One register per cycle through the debug port.
	task automatic check_regs();
		int i;
		for (i = 0; i < 32; i++) begin
			check_reg(reg_idx_t'(i));
		end
	endtask

	function automatic logic probe(input int which);
		case (which)
			W_KILL:  probe = kill;
			W_EXC:   probe = exc_valid;
			default: probe = !stall;
		endcase
	endfunction

	task automatic wait_until(input int which, input string what);
		int cycles;
		cycles = 0;
		while (!probe(which) && cycles < TIMEOUT) begin
			step();
			cycles++;
		end
		if (!probe(which)) begin
			errors++;
			$display("Timeout at %0t while waiting for %s", $time, what);
		end
	endtask

	task automatic issue(input reg_idx_t dest, output word_t pc);
		hist_entry_t entry;
		wait_until(W_FREE, "stall_o to fall");
		pc = next_pc;
		dec = '{valid: 1'b1, pc: pc, dest: dest};
		entry = '{finished: 1'b0, cause: '0, miss_addr: '0, pc: pc, dest: dest,
			old_value: model_regs[dest]};
		model_q.push_back(entry);
		next_pc += 32'd4;
		step();
		dec.valid = 1'b0;
	endtask

	task automatic complete(input word_t pc, input reg_idx_t dest, input word_t data,
			input word_t cause, input word_t addr);
		int i;
		wb = '{valid: 1'b1, pc: pc, dest: dest, data: data, cause: cause, miss_addr: addr};
		for (i = 0; i < model_q.size(); i++) begin
			if (model_q[i].pc == pc && !model_q[i].finished) begin
				model_q[i].finished = 1'b1;
				model_q[i].cause = cause;
				model_q[i].miss_addr = addr;
			end
		end
		if (dest != '0) begin
			model_regs[dest] = data; // Writes land before retirement.
		end
		step();
		wb.valid = 1'b0;
	endtask

	// Clean finished entries leave from the head.
	function automatic void model_retire();
		while (model_q.size() > 0 && model_q[0].finished && model_q[0].cause == '0) begin
			void'(model_q.pop_front());
		end
	endfunction

	task automatic expect_rollback();
		hist_entry_t fault;
		int i;
		model_retire();
		if (model_q.size() == 0) begin
			errors++;
			$display("No faulting entry left in the reference queue at %0t", $time);
			return;
		end
		fault = model_q[0];
		quiet = 1'b0;
		wait_until(W_KILL, "kill_o");
		check("kill_pc_o", fault.pc, kill_pc);
		check("stall_o", 32'd1, word_t'(stall));
		step();
		wait_until(W_EXC, "exc_valid_o");
		check("exc_o.mepc", fault.pc, exc.mepc);
		check("exc_o.mcause", fault.cause, exc.mcause);
		check("exc_o.mtval", fault.miss_addr, exc.mtval);
		check("stall_o", 32'd0, word_t'(stall));
		quiet = 1'b1;
		// Youngest first, so each register ends at its oldest saved value.
		for (i = model_q.size() - 1; i >= 0; i--) begin
			if (model_q[i].dest != '0) begin
				model_regs[model_q[i].dest] = model_q[i].old_value;
			end
		end
		model_q.delete();
		check_regs();
	endtask

	task automatic fill_queue();
		int i;
		for (i = 0; i < HIST_DEPTH; i++) begin
			check("stall_o", 32'd0, word_t'(stall));
			fill_dests[i] = reg_idx_t'($random(seed));
			issue(fill_dests[i], fill_pcs[i]);
		end
		check("stall_o", 32'd1, word_t'(stall));
	endtask

	task automatic reset_state_check();
		check("stall_o", 32'd0, word_t'(stall));
		check("kill_o", 32'd0, word_t'(kill));
		check("exc_valid_o", 32'd0, word_t'(exc_valid));
		check_regs();
	endtask

	task automatic clean_flow();
		word_t    pcs [5];
		reg_idx_t dests [5];
		int       order [5];
		int       i;
		order = '{2, 0, 1, 4, 3};
		for (i = 0; i < 5; i++) begin
			dests[i] = reg_idx_t'($random(seed));
			issue(dests[i], pcs[i]);
		end
		for (i = 0; i < 5; i++) begin
			complete(pcs[order[i]], dests[order[i]], $random(seed), '0, '0);
			check_reg(dests[order[i]]);
		end
		idle(HIST_DEPTH); // One retirement per cycle.
		check_regs();
		fill_queue();
		for (i = 0; i < HIST_DEPTH; i++) begin
			complete(fill_pcs[i], fill_dests[i], $random(seed), '0, '0);
		end
		idle(HIST_DEPTH + 1);
		check_regs();
	endtask

	task automatic full_queue();
		int i;
		fill_queue();
		complete(fill_pcs[0], fill_dests[0], $random(seed), '0, '0);
		wait_until(W_FREE, "stall_o to fall after the oldest writeback");
		for (i = 1; i < HIST_DEPTH; i++) begin
			complete(fill_pcs[i], fill_dests[i], $random(seed), '0, '0);
		end
		idle(HIST_DEPTH + 1);
		check_regs();
	endtask

	task automatic exception_rollback();
		reg_idx_t dests [3];
		word_t    pcs [3];
		int       i;
		dests = '{5'd3, 5'd7, 5'd12};
		for (i = 0; i < 3; i++) begin
			issue(dests[i], pcs[i]);
			complete(pcs[i], dests[i], $random(seed), '0, '0);
		end
		idle(4);
		check_regs();
		for (i = 0; i < 3; i++) begin
			issue(dests[i], pcs[i]);
		end
		complete(pcs[2], dests[2], $random(seed), '0, '0);
		complete(pcs[1], dests[1], $random(seed), '0, '0);
		complete(pcs[0], dests[0], $random(seed), 32'd5, 32'h0000_dea0); // Load fault.
		expect_rollback();
	endtask

	task automatic fault_behind_clean();
		reg_idx_t dests [4];
		word_t    pcs [4];
		int       i;
		dests = '{5'd4, 5'd9, 5'd10, 5'd11};
		for (i = 0; i < 4; i++) begin
			issue(dests[i], pcs[i]);
		end
		complete(pcs[3], dests[3], $random(seed), '0, '0);
		complete(pcs[2], dests[2], $random(seed), 32'd13, $random(seed));
		complete(pcs[1], dests[1], $random(seed), '0, '0);
		complete(pcs[0], dests[0], $random(seed), '0, '0);
		expect_rollback();
	endtask

	task automatic reg_zero();
		word_t pc0;
		word_t pc1;
		word_t pc2;
		issue(5'd0, pc0);
		complete(pc0, 5'd0, 32'hffff_ffff, '0, '0);
		idle(2);
		check_regs();
		issue(5'd0, pc1);
		issue(5'd6, pc2);
		complete(pc2, 5'd6, $random(seed), '0, '0);
		complete(pc1, 5'd0, 32'h1234_5678, 32'd2, pc1);
		expect_rollback();
	endtask

	initial begin
		errors = 0;
		seed = 86158;
		quiet = 1'b1;
		next_pc = 32'h0000_1000;
		rst_i = 1'b1;
		dec = '0;
		wb = '0;
		dbg_addr = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (3) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		reset_state_check();
		clean_flow();
		full_queue();
		exception_rollback();
		fault_behind_clean();
		reg_zero();
		errors += hist_top_i.hist_queue_i.hist_assertions_i.fail_count;
		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
src/hist_pkg.sv
src/reg_file.sv
src/hist_queue.sv
src/exc_regs.sv
src/hist_top.sv
test/hist_assertions.sv
test/hist_top_tb.sv

// File: Bender.yml
package:
  name: hist_top

sources:
  - files:
      - src/hist_pkg.sv
      - src/reg_file.sv
      - src/hist_queue.sv
      - src/exc_regs.sv
      - src/hist_top.sv
  - target: test
    files:
      - test/hist_assertions.sv
      - test/hist_top_tb.sv
